/* verilog/cacheCfgPkg.sv */
// --------------------------------------
// Default cache geometry and word types
// Word addressed memory, one word per line
// numSets and numWays must be powers of two
// --------------------------------------
package cacheCfgPkg;

    // Geometry defaults, the top level may override them
    localparam int defAddrWidth = 12;
    localparam int defDataWidth = 32;
    localparam int defNumSets = 16;
    localparam int defNumWays = 4;

    // Address word at the default width
    typedef logic [defAddrWidth-1:0] addrT;

    // Data word at the default width
    typedef logic [defDataWidth-1:0] dataT;

endpackage

/* verilog/cacheCtrlPkg.sv */
// --------------------------------------
// Controller state and CPU opcode encodings
// --------------------------------------
package cacheCtrlPkg;

    // Access FSM states
    // stMemRead is taken only on a read miss
    typedef enum logic [2:0] {
        stIdle,
        stLookup,
        stMemRead,
        stFill
    } ctrlStateT;

    // CPU request opcode
    typedef enum logic {
        opRead,
        opWrite
    } cpuOpT;

endpackage

/* verilog/mainMemory.sv */
// --------------------------------------
// Single-port word memory, 2^addrWidth words
// Read data appears one cycle after memRdEn
// Contents start at zero, reset clears only the read register
// --------------------------------------
`timescale 1ns/1ns

module mainMemory #(
    parameter int addrWidth = cacheCfgPkg::defAddrWidth,
    parameter int dataWidth = cacheCfgPkg::defDataWidth
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 memWrEn,
    input  logic                 memRdEn,
    input  logic [addrWidth-1:0] memAddr,
    input  logic [dataWidth-1:0] memWrData,
    output logic [dataWidth-1:0] memRdData
);

    localparam int depth = 2 ** addrWidth;

    logic [dataWidth-1:0] mem [depth];

    // Clean start for simulation
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    // Write port
    always @(posedge clk) begin
        if (memWrEn) begin
            mem[memAddr] <= memWrData;
        end
    end

    // Registered read, old data wins on a same-address write
    always_ff @(posedge clk) begin
        if (rst) begin
            memRdData <= '0;
        end else if (memRdEn) begin
            memRdData <= mem[memAddr];
        end
    end

endmodule

/* verilog/tagDataArray.sv */
// --------------------------------------
// Tag, data and valid storage per set and way
// Whole set is read combinationally
// One way written per cycle, a write always validates it
// --------------------------------------
`timescale 1ns/1ns

module tagDataArray #(
    parameter int addrWidth = cacheCfgPkg::defAddrWidth,
    parameter int dataWidth = cacheCfgPkg::defDataWidth,
    parameter int numSets = cacheCfgPkg::defNumSets,
    parameter int numWays = cacheCfgPkg::defNumWays
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [$clog2(numSets)-1:0]     rdSet,
    output logic [numWays*(addrWidth-$clog2(numSets))-1:0] rdTags,
    output logic [numWays*dataWidth-1:0]   rdData,
    output logic [numWays-1:0]             rdValid,
    input  logic                           wrEn,
    input  logic [$clog2(numSets)-1:0]     wrSet,
    input  logic [$clog2(numWays)-1:0]     wrWay,
    input  logic [addrWidth-$clog2(numSets)-1:0] wrTag,
    input  logic [dataWidth-1:0]           wrData
);

    localparam int setW = $clog2(numSets);
    localparam int tagW = addrWidth - setW;

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    logic [tagW-1:0]      tagMem [numSets][numWays];
    logic [dataWidth-1:0] dataMem [numSets][numWays];
    logic [numWays-1:0]   validMem [numSets];

    // Valid bits, the only state that reset touches
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < numSets; s++) begin
                validMem[s] <= '0;
            end
        end else if (wrEn) begin
            validMem[wrSet][wrWay] <= 1'b1;
        end
    end

    // Line payload
    always_ff @(posedge clk) begin
        if (wrEn) begin
            tagMem[wrSet][wrWay] <= wrTag;
            dataMem[wrSet][wrWay] <= wrData;
        end
    end

    // ----------------------------------------
    // Set read, way w sits in slice w
    // ----------------------------------------
    for (genvar w = 0; w < numWays; w++) begin : genRd
        assign rdTags[w*tagW +: tagW] = tagMem[rdSet][w];
        assign rdData[w*dataWidth +: dataWidth] = dataMem[rdSet][w];
    end

    assign rdValid = validMem[rdSet];

    // Write way must name an existing way
    wrWayInRange: assert property (@(posedge clk) disable iff (rst)
        wrEn |-> (wrWay < numWays));

endmodule

/* verilog/lruTracker.sv */
// --------------------------------------
// True LRU ages per line, age 0 is most recent
// Ages in a set stay a permutation of 0..numWays-1
// Reset gives way numWays-1 the oldest age
// --------------------------------------
`timescale 1ns/1ns

module lruTracker #(
    parameter int numSets = cacheCfgPkg::defNumSets,
    parameter int numWays = cacheCfgPkg::defNumWays
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       touchEn,
    input  logic [$clog2(numSets)-1:0] touchSet,
    input  logic [$clog2(numWays)-1:0] touchWay,
    input  logic [$clog2(numSets)-1:0] rdSet,
    output logic [$clog2(numWays)-1:0] victimWay
);

    localparam int setW = $clog2(numSets);
    localparam int wayW = $clog2(numWays);
    localparam int ageW = $clog2(numWays);

    logic [ageW-1:0] ages [numSets][numWays];
    logic [ageW-1:0] oldAge;
    logic [ageW-1:0] bestAge;

    // Age of the way being touched, before the update
    assign oldAge = ages[touchSet][touchWay];

    // Touched way becomes youngest, younger ways age by one
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < numSets; s++) begin
                for (int w = 0; w < numWays; w++) begin
                    ages[s][w] <= ageW'(w);
                end
            end
        end else if (touchEn) begin
            for (int w = 0; w < numWays; w++) begin
                if (w == touchWay) begin
                    ages[touchSet][w] <= '0;
                end else if (ages[touchSet][w] < oldAge) begin
                    ages[touchSet][w] <= ages[touchSet][w] + 1'b1;
                end
            end
        end
    end

    // Oldest way of the looked-up set
    always_comb begin
        victimWay = '0;
        bestAge = '0;
        for (int w = 0; w < numWays; w++) begin
            if (ages[rdSet][w] > bestAge) begin
                bestAge = ages[rdSet][w];
                victimWay = wayW'(w);
            end
        end
    end

    // Pairwise check that no two ways of a set share an age
    function automatic logic agesDistinct(input logic [setW-1:0] s);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < numWays; i++) begin
            for (int j = i + 1; j < numWays; j++) begin
                if (ages[s][i] == ages[s][j]) begin
                    ok = 1'b0;
                end
            end
        end
        return ok;
    endfunction

    agesStayDistinct: assert property (@(posedge clk) disable iff (rst)
        touchEn |=> agesDistinct($past(touchSet)));

endmodule

/* verilog/cacheController.sv */
// --------------------------------------
// Write-through cache FSM, one request in flight
// Hit 2 cycles, write miss 3, read miss 4
// Write miss allocates without a memory read
// respValid is a one-cycle pulse with no back-pressure
// --------------------------------------
`timescale 1ns/1ns

module cacheController #(
    parameter int addrWidth = cacheCfgPkg::defAddrWidth,
    parameter int dataWidth = cacheCfgPkg::defDataWidth,
    parameter int numSets = cacheCfgPkg::defNumSets,
    parameter int numWays = cacheCfgPkg::defNumWays
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       reqValid,
    input  cacheCtrlPkg::cpuOpT        reqOp,
    input  logic [addrWidth-1:0]       reqAddr,
    input  logic [dataWidth-1:0]       reqWriteData,
    output logic                       reqReady,
    output logic                       respValid,
    output logic [dataWidth-1:0]       respReadData,
    output logic [$clog2(numSets)-1:0] rdSet,
    input  logic [numWays*(addrWidth-$clog2(numSets))-1:0] rdTags,
    input  logic [numWays*dataWidth-1:0] rdData,
    input  logic [numWays-1:0]         rdValid,
    output logic                       wrEn,
    output logic [$clog2(numSets)-1:0] wrSet,
    output logic [$clog2(numWays)-1:0] wrWay,
    output logic [addrWidth-$clog2(numSets)-1:0] wrTag,
    output logic [dataWidth-1:0]       wrData,
    output logic                       touchEn,
    output logic [$clog2(numSets)-1:0] touchSet,
    output logic [$clog2(numWays)-1:0] touchWay,
    input  logic [$clog2(numWays)-1:0] victimWay,
    output logic                       memWrEn,
    output logic                       memRdEn,
    output logic [addrWidth-1:0]       memAddr,
    output logic [dataWidth-1:0]       memWrData,
    input  logic [dataWidth-1:0]       memRdData
);

    localparam int setW = $clog2(numSets);
    localparam int wayW = $clog2(numWays);
    localparam int tagW = addrWidth - setW;

    cacheCtrlPkg::ctrlStateT state, nextState;

    // Latched request
    logic [addrWidth-1:0] addrQ;
    logic [dataWidth-1:0] wdataQ;
    cacheCtrlPkg::cpuOpT  opQ;
    logic [wayW-1:0]      replWayQ;

    // Set index in the low bits, tag above it
    logic [setW-1:0] setQ;
    logic [tagW-1:0] tagQ;
    assign setQ = addrQ[setW-1:0];
    assign tagQ = addrQ[addrWidth-1:setW];

    // ----------------------------------------
    // Hit detection and replacement choice
    // ----------------------------------------
    logic                 hit;
    logic [wayW-1:0]      hitWay;
    logic [dataWidth-1:0] hitData;
    logic                 foundInvalid;
    logic [wayW-1:0]      invalidWay;
    logic [wayW-1:0]      replWay;

    // Downward scan so the lowest invalid way wins
    always_comb begin
        hit = 1'b0;
        hitWay = '0;
        hitData = '0;
        foundInvalid = 1'b0;
        invalidWay = '0;
        for (int w = numWays - 1; w >= 0; w--) begin
            if (!rdValid[w]) begin
                foundInvalid = 1'b1;
                invalidWay = wayW'(w);
            end
            if (rdValid[w] && rdTags[w*tagW +: tagW] == tagQ) begin
                hit = 1'b1;
                hitWay = wayW'(w);
                hitData = rdData[w*dataWidth +: dataWidth];
            end
        end
    end

    // Invalid ways first, then the LRU victim
    assign replWay = foundInvalid ? invalidWay : victimWay;

    assign reqReady = (state == cacheCtrlPkg::stIdle);

    // ----------------------------------------
    // Next state
    // ----------------------------------------
    always_comb begin
        nextState = state;
        case (state)
            cacheCtrlPkg::stIdle: begin
                if (reqValid) begin
                    nextState = cacheCtrlPkg::stLookup;
                end
            end
            cacheCtrlPkg::stLookup: begin
                if (hit) begin
                    nextState = cacheCtrlPkg::stIdle;
                end else if (opQ == cacheCtrlPkg::opRead) begin
                    nextState = cacheCtrlPkg::stMemRead;
                end else begin
                    nextState = cacheCtrlPkg::stFill;
                end
            end
            // Memory data lands for the fill
            cacheCtrlPkg::stMemRead: nextState = cacheCtrlPkg::stFill;
            cacheCtrlPkg::stFill: nextState = cacheCtrlPkg::stIdle;
            default: nextState = cacheCtrlPkg::stIdle;
        endcase
    end

    // ----------------------------------------
    // Array, LRU and memory controls
    // ----------------------------------------
    always_comb begin
        rdSet = setQ;
        wrEn = 1'b0;
        wrSet = setQ;
        wrWay = replWayQ;
        wrTag = tagQ;
        wrData = wdataQ;
        touchEn = 1'b0;
        touchSet = setQ;
        touchWay = replWayQ;
        memWrEn = 1'b0;
        memRdEn = 1'b0;
        memAddr = addrQ;
        memWrData = wdataQ;
        case (state)
            cacheCtrlPkg::stLookup: begin
                if (hit) begin
                    touchEn = 1'b1;
                    touchWay = hitWay;
                    // Write hit updates line and memory together
                    if (opQ == cacheCtrlPkg::opWrite) begin
                        wrEn = 1'b1;
                        wrWay = hitWay;
                        memWrEn = 1'b1;
                    end
                end
            end
            cacheCtrlPkg::stMemRead: memRdEn = 1'b1;
            cacheCtrlPkg::stFill: begin
                wrEn = 1'b1;
                touchEn = 1'b1;
                if (opQ == cacheCtrlPkg::opRead) begin
                    wrData = memRdData;
                end else begin
                    memWrEn = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // ----------------------------------------
    // State and response pulse
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cacheCtrlPkg::stIdle;
            respValid <= 1'b0;
        end else begin
            state <= nextState;
            respValid <= (state == cacheCtrlPkg::stLookup && hit) ||
                         (state == cacheCtrlPkg::stFill);
        end
    end

    // Request latch, replacement way and read data
    always_ff @(posedge clk) begin
        if (reqValid && reqReady) begin
            addrQ <= reqAddr;
            wdataQ <= reqWriteData;
            opQ <= reqOp;
        end
        if (state == cacheCtrlPkg::stLookup && !hit) begin
            replWayQ <= replWay;
        end
        // Read data holds until the next read completes
        if (opQ == cacheCtrlPkg::opRead) begin
            if (state == cacheCtrlPkg::stLookup && hit) begin
                respReadData <= hitData;
            end else if (state == cacheCtrlPkg::stFill) begin
                respReadData <= memRdData;
            end
        end
    end

    respSinglePulse: assert property (@(posedge clk) disable iff (rst)
        respValid |=> !respValid);

    memPortExclusive: assert property (@(posedge clk) disable iff (rst)
        !(memRdEn && memWrEn));

endmodule

/* verilog/cacheTop.sv */
// --------------------------------------
// Write-through set-associative cache with main memory
// Geometry defaults come from cacheCfgPkg
// --------------------------------------
`timescale 1ns/1ns

module cacheTop #(
    parameter int addrWidth = cacheCfgPkg::defAddrWidth,
    parameter int dataWidth = cacheCfgPkg::defDataWidth,
    parameter int numSets = cacheCfgPkg::defNumSets,
    parameter int numWays = cacheCfgPkg::defNumWays
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 reqValid,
    input  cacheCtrlPkg::cpuOpT  reqOp,
    input  logic [addrWidth-1:0] reqAddr,
    input  logic [dataWidth-1:0] reqWriteData,
    output logic                 reqReady,
    output logic                 respValid,
    output logic [dataWidth-1:0] respReadData
);

    localparam int setW = $clog2(numSets);
    localparam int wayW = $clog2(numWays);
    localparam int tagW = addrWidth - setW;

    // Controller to arrays
    logic [setW-1:0]              rdSet;
    logic [numWays*tagW-1:0]      rdTags;
    logic [numWays*dataWidth-1:0] rdData;
    logic [numWays-1:0]           rdValid;
    logic                         wrEn;
    logic [setW-1:0]              wrSet;
    logic [wayW-1:0]              wrWay;
    logic [tagW-1:0]              wrTag;
    logic [dataWidth-1:0]         wrData;
    logic                         touchEn;
    logic [setW-1:0]              touchSet;
    logic [wayW-1:0]              touchWay;
    logic [wayW-1:0]              victimWay;

    // Controller to memory
    logic                 memWrEn;
    logic                 memRdEn;
    logic [addrWidth-1:0] memAddr;
    logic [dataWidth-1:0] memWrData;
    logic [dataWidth-1:0] memRdData;

    cacheController #(
        .addrWidth(addrWidth), .dataWidth(dataWidth),
        .numSets(numSets), .numWays(numWays)
    ) ctrl0 (
        .clk, .rst, .reqValid, .reqOp, .reqAddr, .reqWriteData,
        .reqReady, .respValid, .respReadData,
        .rdSet, .rdTags, .rdData, .rdValid,
        .wrEn, .wrSet, .wrWay, .wrTag, .wrData,
        .touchEn, .touchSet, .touchWay, .victimWay,
        .memWrEn, .memRdEn, .memAddr, .memWrData, .memRdData
    );

    tagDataArray #(
        .addrWidth(addrWidth), .dataWidth(dataWidth),
        .numSets(numSets), .numWays(numWays)
    ) array0 (
        .clk, .rst, .rdSet, .rdTags, .rdData, .rdValid,
        .wrEn, .wrSet, .wrWay, .wrTag, .wrData
    );

    // Victim lookup shares the controller's read set
    lruTracker #(
        .numSets(numSets), .numWays(numWays)
    ) lru0 (
        .clk, .rst, .touchEn, .touchSet, .touchWay, .rdSet, .victimWay
    );

    mainMemory #(
        .addrWidth(addrWidth), .dataWidth(dataWidth)
    ) mem0 (
        .clk, .rst, .memWrEn, .memRdEn, .memAddr, .memWrData, .memRdData
    );

endmodule

/* tb/tbVectors.svh */
// --------------------------------------
// Directed stimulus for the cache testbench
// Address bits 3:0 are the set, bits 11:4 the tag
// Latency classes assume a 4-way, 16-set cache
// --------------------------------------
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Latency classes in cycles from accept edge to respValid
localparam logic [2:0] latHit = 3'd2;
localparam logic [2:0] latWrMiss = 3'd3;
localparam logic [2:0] latRdMiss = 3'd4;

// Columns: op, address, write data, expected latency class
typedef struct packed {
    cacheCtrlPkg::cpuOpT op;
    cacheCfgPkg::addrT   addr;
    cacheCfgPkg::dataT   wdata;
    logic [2:0]          lat;
} vecRowT;

localparam int numVecRows = 19;

localparam vecRowT vecTable [numVecRows] = '{
    // Cold read returns zero
    '{cacheCtrlPkg::opRead,  12'h100, 32'h0000_0000, latRdMiss},
    // Write allocate, then hits on the same line
    '{cacheCtrlPkg::opWrite, 12'h023, 32'hA5A5_0001, latWrMiss},
    '{cacheCtrlPkg::opRead,  12'h023, 32'h0000_0000, latHit},
    '{cacheCtrlPkg::opWrite, 12'h023, 32'h5A5A_0002, latHit},
    '{cacheCtrlPkg::opRead,  12'h023, 32'h0000_0000, latHit},
    // Fill all four ways of set 5
    '{cacheCtrlPkg::opWrite, 12'h005, 32'h1111_0005, latWrMiss},
    '{cacheCtrlPkg::opWrite, 12'h015, 32'h2222_0015, latWrMiss},
    '{cacheCtrlPkg::opWrite, 12'h025, 32'h3333_0025, latWrMiss},
    '{cacheCtrlPkg::opWrite, 12'h035, 32'h4444_0035, latWrMiss},
    // Repeat reads hit, 0x005 ends up oldest
    '{cacheCtrlPkg::opRead,  12'h005, 32'h0000_0000, latHit},
    '{cacheCtrlPkg::opRead,  12'h015, 32'h0000_0000, latHit},
    '{cacheCtrlPkg::opRead,  12'h025, 32'h0000_0000, latHit},
    '{cacheCtrlPkg::opRead,  12'h035, 32'h0000_0000, latHit},
    // Fifth tag evicts 0x005
    '{cacheCtrlPkg::opWrite, 12'h045, 32'h5555_0045, latWrMiss},
    // Evicted line comes back from memory and evicts 0x015
    '{cacheCtrlPkg::opRead,  12'h005, 32'h0000_0000, latRdMiss},
    '{cacheCtrlPkg::opRead,  12'h035, 32'h0000_0000, latHit},
    '{cacheCtrlPkg::opRead,  12'h045, 32'h0000_0000, latHit},
    '{cacheCtrlPkg::opRead,  12'h015, 32'h0000_0000, latRdMiss},
    '{cacheCtrlPkg::opRead,  12'h025, 32'h0000_0000, latRdMiss}
};

`endif

/* tb/cacheTb.sv */
// --------------------------------------
// Testbench for the write-through cache
// Directed table first, then random rows in set 9
// Random rows are checked for read data only
// --------------------------------------
`timescale 1ns/1ns

module cacheTb;

    `include "tbVectors.svh"

    localparam int resetCycles = 2;
    localparam int numRandRows = 40;
    localparam int maxWait = 16;
    localparam int watchdogCycles = (numVecRows + numRandRows) * 10 + resetCycles + 1;
    localparam logic [3:0] randSet = 4'h9;

    logic                clk;
    logic                rst;
    logic                reqValid;
    cacheCtrlPkg::cpuOpT reqOp;
    cacheCfgPkg::addrT   reqAddr;
    cacheCfgPkg::dataT   reqWriteData;
    logic                reqReady;
    logic                respValid;
    cacheCfgPkg::dataT   respReadData;

    // Reference memory, write-through makes it the expected read value
    cacheCfgPkg::dataT modelMem [2 ** cacheCfgPkg::defAddrWidth];

    int dataErrors;
    int latencyErrors;
    int flagErrors;
    int otherErrors;
    logic [15:0] lfsrState;

    cacheTop dut0 (
        .clk, .rst, .reqValid, .reqOp, .reqAddr, .reqWriteData,
        .reqReady, .respValid, .respReadData
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic checkData(input string name, input cacheCfgPkg::dataT got,
                             input cacheCfgPkg::dataT exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
            dataErrors++;
        end
    endtask

    task automatic checkLatency(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            latencyErrors++;
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            flagErrors++;
        end
    endtask

    // ----------------------------------------
    // Random source, 16-bit Fibonacci LFSR
    // ----------------------------------------
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        logic fb;
        fb = s[0] ^ s[2] ^ s[3] ^ s[5];
        return {fb, s[15:1]};
    endfunction

    // One step per bit, shifted-out bit is the sample
    task automatic takeBits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    // ----------------------------------------
    // One request, called just after a rising edge
    // ----------------------------------------
    task automatic runRequest(input cacheCtrlPkg::cpuOpT op, input cacheCfgPkg::addrT addr,
                              input cacheCfgPkg::dataT wdata, output int cycles,
                              output cacheCfgPkg::dataT rdata, output bit ok);
        int waitCount;
        ok = 1'b0;
        cycles = 0;
        rdata = '0;
        reqValid <= 1'b1;
        reqOp <= op;
        reqAddr <= addr;
        reqWriteData <= wdata;
        // Accept edge is the first one that sees reqReady high
        waitCount = 0;
        @(posedge clk);
        while (!reqReady && waitCount < maxWait) begin
            @(posedge clk);
            waitCount++;
        end
        reqValid <= 1'b0;
        if (!reqReady) begin
            $display("Request to address 0x%03h was never accepted", addr);
            otherErrors++;
            return;
        end
        // Count edges until respValid is seen high
        do begin
            @(posedge clk);
            cycles++;
        end while (!respValid && cycles < maxWait);
        if (!respValid) begin
            $display("No response for address 0x%03h within %0d cycles", addr, maxWait);
            otherErrors++;
            return;
        end
        rdata = respReadData;
        ok = 1'b1;
    endtask

    task automatic printCounts();
        $display("Errors: data %0d, latency %0d, flag %0d, other %0d",
                 dataErrors, latencyErrors, flagErrors, otherErrors);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        vecRowT              row;
        int                  cycles;
        bit                  ok;
        cacheCfgPkg::dataT   rdata;
        cacheCtrlPkg::cpuOpT op;
        cacheCfgPkg::addrT   addr;
        logic [31:0]         bits;
        cacheCfgPkg::dataT   wdata;

        rst = 1'b1;
        reqValid = 1'b0;
        reqOp = cacheCtrlPkg::opRead;
        reqAddr = '0;
        reqWriteData = '0;
        dataErrors = 0;
        latencyErrors = 0;
        flagErrors = 0;
        otherErrors = 0;
        lfsrState = 16'd23;
        for (int i = 0; i < 2 ** cacheCfgPkg::defAddrWidth; i++) begin
            modelMem[i] = '0;
        end

        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        // Idle outputs right after reset
        checkFlag("reqReady", reqReady, 1'b1);
        checkFlag("respValid", respValid, 1'b0);

        // Directed rows, latency and data
        for (int i = 0; i < numVecRows; i++) begin
            row = vecTable[i];
            runRequest(row.op, row.addr, row.wdata, cycles, rdata, ok);
            if (ok) begin
                checkLatency($sformatf("respValid latency row %0d", i), cycles, int'(row.lat));
                if (row.op == cacheCtrlPkg::opRead) begin
                    checkData($sformatf("respReadData @0x%03h", row.addr), rdata,
                              modelMem[row.addr]);
                end
            end
            if (row.op == cacheCtrlPkg::opWrite) begin
                modelMem[row.addr] = row.wdata;
            end
        end

        // Random rows, 8 tags in one set force LRU evictions
        for (int i = 0; i < numRandRows; i++) begin
            takeBits(1, bits);
            op = bits[0] ? cacheCtrlPkg::opWrite : cacheCtrlPkg::opRead;
            takeBits(3, bits);
            addr = {5'b0, bits[2:0], randSet};
            takeBits(32, bits);
            wdata = bits;
            runRequest(op, addr, wdata, cycles, rdata, ok);
            if (ok && op == cacheCtrlPkg::opRead) begin
                checkData($sformatf("respReadData @0x%03h", addr), rdata, modelMem[addr]);
            end
            if (op == cacheCtrlPkg::opWrite) begin
                modelMem[addr] = wdata;
            end
        end

        printCounts();
        if (dataErrors + latencyErrors + flagErrors + otherErrors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog, bound from the row count
    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout: run still going after %0d cycles", watchdogCycles);
        printCounts();
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* src.f */
+incdir+tb
verilog/cacheCfgPkg.sv
verilog/cacheCtrlPkg.sv
verilog/mainMemory.sv
verilog/tagDataArray.sv
verilog/lruTracker.sv
verilog/cacheController.sv
verilog/cacheTop.sv
tb/cacheTb.sv

/* Bender.yml */
package:
  name: cache_wt

sources:
  - verilog/cacheCfgPkg.sv
  - verilog/cacheCtrlPkg.sv
  - verilog/mainMemory.sv
  - verilog/tagDataArray.sv
  - verilog/lruTracker.sv
  - verilog/cacheController.sv
  - verilog/cacheTop.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/cacheTb.sv
